/* umi_defines.svh */
/* umi device defines
   packet widths, group decode and register count */

`ifndef UMI_DEFINES_SVH
`define UMI_DEFINES_SVH

//####################
// packet fields
//####################
`define UMI_AW 64         // address width
`define UMI_CW 32         // command width
`define UMI_DW 256        // packet data width

//####################
// register bank
//####################
`define UMI_RW 64         // register width
`define UMI_NREGS 16      // register count

//####################
// group decode
//####################
// group field sits in the destination address
`define UMI_GRPOFFSET 24  // lowest group bit
`define UMI_GRPAW 4       // group field width
`define UMI_GRPID 0       // this device's group

`endif

/* umi_pkg.sv */
/* umi package
   packet field types, opcodes and command word pack/unpack */

`default_nettype none

`include "umi_defines.svh"

package umi_pkg;

   //####################
   // field types
   //####################
   typedef logic [`UMI_AW-1:0] umi_addr_t;     // address word
   typedef logic [`UMI_CW-1:0] umi_cmd_word_t; // raw command
   typedef logic [`UMI_DW-1:0] umi_data_t;     // packet data
   typedef logic [`UMI_RW-1:0] reg_data_t;     // register data

   // opcodes in cmd[4:0]
   typedef enum logic [4:0] {
      REQ_READ       = 5'd1,
      RESP_READ      = 5'd2,
      REQ_WRITE      = 5'd3,
      REQ_ATOMIC_ADD = 5'd9
   } umi_opcode_e;

   // decoded command, msb first
   typedef struct packed {
      logic [`UMI_CW-9:0] options; // bits 31:8
      logic [2:0]         size;    // 2**size bytes
      umi_opcode_e        opcode;  // bits 4:0
   } umi_cmd_t;

   //####################
   // pack / unpack
   //####################
   function automatic umi_cmd_t umi_unpack(input umi_cmd_word_t word);
      umi_cmd_t cmd;
      cmd.opcode  = umi_opcode_e'(word[4:0]); // raw value kept
      cmd.size    = word[7:5];
      cmd.options = word[`UMI_CW-1:8];
      return cmd;
   endfunction

   function automatic umi_cmd_word_t umi_pack(input umi_cmd_t cmd);
      umi_cmd_word_t word;
      word[4:0]         = cmd.opcode;
      word[7:5]         = cmd.size;
      word[`UMI_CW-1:8] = cmd.options;
      return word;
   endfunction

endpackage

`default_nettype wire

/* reg_if.sv */
/* register access bus
   strobes and data between the umi translator and the bank */

`default_nettype none

`include "umi_defines.svh"

interface reg_if
   import umi_pkg::*;
   ();

   umi_addr_t   addr;   // full request address
   logic        read;   // one-cycle read strobe
   logic        write;  // one-cycle write strobe
   umi_opcode_e opcode; // selects plain vs atomic write
   logic [2:0]  size;   // byte count is 2**size
   reg_data_t   wrdata; // write data / add operand
   reg_data_t   rddata; // registered read data

   modport ctrl (output addr, read, write, opcode, size, wrdata, input rddata);
   modport bank (input addr, read, write, opcode, size, wrdata, output rddata);

endinterface

`default_nettype wire

/* umi_regif.sv */
/* umi register interface
   turns umi requests into register strobes and returns read responses */

`default_nettype none

`include "umi_defines.svh"

module umi_regif
   import umi_pkg::*;
   #(parameter logic [`UMI_GRPAW-1:0] grp_id = '0) // group this device answers
   (
      input  logic          clk,
      input  logic          nreset,
      // umi request
      input  logic          req_valid,
      input  umi_cmd_word_t req_cmd,
      input  umi_addr_t     req_dstaddr,
      input  umi_addr_t     req_srcaddr,
      input  umi_data_t     req_data,
      output logic          req_ready,
      // umi response
      output logic          resp_valid,
      output umi_cmd_word_t resp_cmd,
      output umi_addr_t     resp_dstaddr,
      output umi_addr_t     resp_srcaddr,
      output umi_data_t     resp_data,
      input  logic          resp_ready,
      // register side
      reg_if.ctrl           regs
   );

   umi_cmd_t  req_dec;     // unpacked request command
   logic      group_match; // dst group hits this device
   logic      req_accept;  // request handshake
   logic      is_read;     // read or atomic
   logic      is_write;    // write or atomic
   umi_cmd_t  resp_cmd_q;  // captured request command
   umi_addr_t resp_dst_q;  // captured request source
   umi_cmd_t  resp_dec;    // response command before pack

   //####################
   // request decode
   //####################
   always_comb begin
      req_dec = umi_unpack(req_cmd);
   end

   assign group_match = (req_dstaddr[`UMI_GRPOFFSET +: `UMI_GRPAW] == grp_id);
   assign req_accept  = req_valid & req_ready;

   assign is_read  = (req_dec.opcode == REQ_READ) | (req_dec.opcode == REQ_ATOMIC_ADD);
   assign is_write = (req_dec.opcode == REQ_WRITE) | (req_dec.opcode == REQ_ATOMIC_ADD);

   // strobes only on a group hit, misses are swallowed
   assign regs.read   = req_accept & group_match & is_read;
   assign regs.write  = req_accept & group_match & is_write;
   assign regs.addr   = req_dstaddr;
   assign regs.opcode = req_dec.opcode;
   assign regs.size   = req_dec.size;
   assign regs.wrdata = req_data[`UMI_RW-1:0]; // low lane only

   // ready toggles while traffic flows, so one gap after each accept
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         req_ready <= 1'b0;
      end else if (req_valid & resp_ready) begin
         req_ready <= ~req_ready;
      end else begin
         req_ready <= 1'b0; // stall on back-pressure
      end
   end

   //####################
   // response
   //####################
   // new read wins over the handshake so back-to-back stays valid
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         resp_valid <= 1'b0;
      end else if (regs.read) begin
         resp_valid <= 1'b1;
      end else if (resp_valid & resp_ready) begin
         resp_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (regs.read) begin
         resp_cmd_q <= req_dec;     // size and options echoed back
         resp_dst_q <= req_srcaddr; // reply goes to the requester
      end
   end

   always_comb begin
      resp_dec        = resp_cmd_q;
      resp_dec.opcode = RESP_READ;
   end

   assign resp_cmd     = umi_pack(resp_dec);
   assign resp_dstaddr = resp_dst_q;
   assign resp_srcaddr = '0;
   assign resp_data    = {(`UMI_DW/`UMI_RW){regs.rddata}}; // all lanes same

endmodule

`default_nettype wire

/* umi_reg_file.sv */
/* register bank
   sixteen 64-bit registers with masked write, atomic add and registered read */

`default_nettype none

`include "umi_defines.svh"

module umi_reg_file
   import umi_pkg::*;
   (
      input  logic clk,
      input  logic nreset,
      reg_if.bank  regs
   );

   localparam int idx_w = $clog2(`UMI_NREGS); // register index bits

   reg_data_t        mem [`UMI_NREGS]; // the registers
   logic [idx_w-1:0] idx;              // addressed register
   reg_data_t        old_val;          // current contents
   reg_data_t        byte_mask;        // bytes touched by a write
   reg_data_t        wr_val;           // next contents

   // low 2**size bytes set
   function automatic reg_data_t size_mask(input logic [2:0] size);
      reg_data_t mask;
      mask = '0;
      for (int i = 0; i < `UMI_RW/8; i++) begin
         if (i < (1 << size)) begin
            mask[i*8 +: 8] = 8'hff;
         end
      end
      return mask;
   endfunction

   //####################
   // write data path
   //####################
   assign idx       = regs.addr[3 +: idx_w]; // 8-byte aligned regs
   assign old_val   = mem[idx];
   assign byte_mask = size_mask(regs.size);

   always_comb begin
      if (regs.opcode == REQ_ATOMIC_ADD) begin
         wr_val = old_val + regs.wrdata; // wraps at 2**64
      end else begin
         wr_val = (old_val & ~byte_mask) | (regs.wrdata & byte_mask);
      end
   end

   //####################
   // storage
   //####################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         for (int i = 0; i < `UMI_NREGS; i++) begin
            mem[i] <= '0;
         end
      end else if (regs.write) begin
         mem[idx] <= wr_val;
      end
   end

   // old value, so an atomic returns the pre-add contents
   always_ff @(posedge clk) begin
      if (regs.read) begin
         regs.rddata <= old_val;
      end
   end

endmodule

`default_nettype wire

/* umi_dev_top.sv */
/* umi device endpoint
   umi request/response ports over a small register bank */

`default_nettype none

`include "umi_defines.svh"

module umi_dev_top
   import umi_pkg::*;
   (
      input  logic          clk,
      input  logic          nreset,
      // umi request
      input  logic          req_valid,
      input  umi_cmd_word_t req_cmd,
      input  umi_addr_t     req_dstaddr,
      input  umi_addr_t     req_srcaddr,
      input  umi_data_t     req_data,
      output logic          req_ready,
      // umi response
      output logic          resp_valid,
      output umi_cmd_word_t resp_cmd,
      output umi_addr_t     resp_dstaddr,
      output umi_addr_t     resp_srcaddr,
      output umi_data_t     resp_data,
      input  logic          resp_ready
   );

   reg_if regs (); // translator to bank

   //####################
   // umi translator
   //####################
   umi_regif #(
      .grp_id (`UMI_GRPAW'(`UMI_GRPID))
   ) u_regif (
      .clk          (clk),
      .nreset       (nreset),
      .req_valid    (req_valid),
      .req_cmd      (req_cmd),
      .req_dstaddr  (req_dstaddr),
      .req_srcaddr  (req_srcaddr),
      .req_data     (req_data),
      .req_ready    (req_ready),
      .resp_valid   (resp_valid),
      .resp_cmd     (resp_cmd),
      .resp_dstaddr (resp_dstaddr),
      .resp_srcaddr (resp_srcaddr),
      .resp_data    (resp_data),
      .resp_ready   (resp_ready),
      .regs         (regs.ctrl)
   );

   //####################
   // register bank
   //####################
   umi_reg_file u_reg_file (
      .clk    (clk),
      .nreset (nreset),
      .regs   (regs.bank)
   );

endmodule

`default_nettype wire

/* tb_umi_tasks.svh */
/* umi device testbench tasks
   request driver, response capture, typed compares and directed tests */

`ifndef TB_UMI_TASKS_SVH
`define TB_UMI_TASKS_SVH

//####################
// compares
//####################
task automatic check_flag(input string name, input logic exp, input logic act);
   n_checks++;
   if (act !== exp) begin
      n_errors++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
   end
endtask

task automatic check_data(input string name, input reg_data_t exp, input reg_data_t act);
   n_checks++;
   if (act !== exp) begin
      n_errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
   end
endtask

task automatic check_addr(input string name, input umi_addr_t exp, input umi_addr_t act);
   n_checks++;
   if (act !== exp) begin
      n_errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
   end
endtask

task automatic check_cmd(input string name, input umi_cmd_t exp, input umi_cmd_t act);
   n_checks++;
   if (act !== exp) begin
      n_errors++;
      $display("CHECK FAILED %s: expected op %0d size %0d opt %h, actual op %0d size %0d opt %h",
               name, exp.opcode, exp.size, exp.options, act.opcode, act.size, act.options);
   end
endtask

//####################
// helpers
//####################
function automatic reg_data_t rand64();
   reg_data_t v;
   v[63:32] = $random(seed);
   v[31:0]  = $random(seed);
   return v;
endfunction

// index in bits 6:3, group in its own field
function automatic umi_addr_t reg_addr(input int idx, input logic [`UMI_GRPAW-1:0] grp);
   umi_addr_t a;
   a = '0;
   a[6:3] = idx[3:0];
   a[`UMI_GRPOFFSET +: `UMI_GRPAW] = grp;
   return a;
endfunction

// low 2**size bytes taken from val
function automatic reg_data_t merge(input reg_data_t old, input reg_data_t val,
                                    input logic [2:0] size);
   reg_data_t keep;
   keep = (size >= 3) ? '0 : ~((64'd1 << (8 << size)) - 64'd1);
   return (old & keep) | (val & ~keep);
endfunction

//####################
// driver
//####################
task automatic drive_req(input umi_opcode_e op, input logic [2:0] size, input umi_addr_t dst,
                         input umi_addr_t src, input reg_data_t wdata, output umi_cmd_t cmd);
   logic [31:0] r;
   r = $random(seed);
   cmd.opcode  = op;
   cmd.size    = size;
   cmd.options = r[23:0]; // random options, echoed on reads
   req_cmd     = cmd;
   req_dstaddr = dst;
   req_srcaddr = src;
   req_data    = {rand64(), rand64(), rand64(), wdata}; // upper lanes ignored
   req_valid   = 1'b1;
endtask

// ready at a falling edge means the next rising edge accepts
task automatic wait_accept();
   while (!req_ready) begin
      @(negedge clk);
   end
   @(negedge clk);
   req_valid = 1'b0;
endtask

task automatic send_req(input umi_opcode_e op, input logic [2:0] size, input umi_addr_t dst,
                        input umi_addr_t src, input reg_data_t wdata, output umi_cmd_t cmd);
   drive_req(op, size, dst, src, wdata, cmd);
   wait_accept();
endtask

task automatic get_resp(output umi_cmd_t cmd, output umi_addr_t dst, output umi_addr_t src,
                        output umi_data_t data);
   while (!resp_valid) begin
      @(negedge clk);
   end
   cmd  = umi_cmd_t'(resp_cmd);
   dst  = resp_dstaddr;
   src  = resp_srcaddr;
   data = resp_data;
   @(negedge clk); // consumed at the rising edge between
endtask

// next response against the request it answers
task automatic check_resp(input string name, input umi_cmd_t req, input umi_addr_t req_src,
                          input reg_data_t exp);
   umi_cmd_t  want;
   umi_cmd_t  cmd;
   umi_addr_t dst;
   umi_addr_t src;
   umi_data_t data;
   want        = req;
   want.opcode = RESP_READ;
   get_resp(cmd, dst, src, data);
   check_cmd({name, " cmd"}, want, cmd);
   check_addr({name, " dst"}, req_src, dst);
   check_addr({name, " src"}, '0, src);
   for (int l = 0; l < `UMI_DW / `UMI_RW; l++) begin
      check_data($sformatf("%s lane %0d", name, l), exp, data[l*`UMI_RW +: `UMI_RW]);
   end
endtask

//####################
// register ops
//####################
task automatic write_reg(input int idx, input logic [2:0] size, input reg_data_t val);
   umi_cmd_t cmd;
   send_req(REQ_WRITE, size, reg_addr(idx, '0), rand64(), val, cmd);
   model[idx] = merge(model[idx], val, size); // posted, no response
endtask

task automatic read_reg(input string name, input int idx);
   umi_cmd_t  cmd;
   umi_addr_t src;
   src = rand64();
   send_req(REQ_READ, 3'd3, reg_addr(idx, '0), src, rand64(), cmd);
   check_resp($sformatf("%s reg %0d", name, idx), cmd, src, model[idx]);
endtask

task automatic atomic_add(input string name, input int idx, input reg_data_t operand);
   umi_cmd_t  cmd;
   umi_addr_t src;
   src = rand64();
   send_req(REQ_ATOMIC_ADD, 3'd3, reg_addr(idx, '0), src, operand, cmd);
   check_resp($sformatf("%s reg %0d", name, idx), cmd, src, model[idx]); // old value
   model[idx] = model[idx] + operand; // wraps at 2**64
endtask

//####################
// directed tests
//####################
task automatic test_reset_rw();
   check_flag("reset_rw req_ready", 1'b0, req_ready);
   check_flag("reset_rw resp_valid", 1'b0, resp_valid);
   for (int i = 0; i < `UMI_NREGS; i++) begin
      write_reg(i, 3'd3, rand64());
   end
   for (int i = 0; i < `UMI_NREGS; i++) begin
      read_reg("reset_rw", i);
   end
endtask

task automatic test_masked_write();
   for (int s = 0; s < 3; s++) begin
      write_reg(2 + s, s[2:0], rand64()); // 1, 2, 4 bytes over old data
      read_reg("masked_write", 2 + s);
   end
endtask

task automatic test_atomic_add();
   atomic_add("atomic_add", 5, rand64());
   read_reg("atomic_add", 5);
   write_reg(6, 3'd3, 64'hffff_ffff_ffff_fff0);
   atomic_add("atomic_add wrap", 6, 64'h25); // carries out of bit 63
   read_reg("atomic_add wrap", 6);
endtask

task automatic test_group_miss();
   umi_cmd_t cmd;
   send_req(REQ_WRITE, 3'd3, reg_addr(7, 4'h3), rand64(), rand64(), cmd);
   send_req(REQ_READ, 3'd3, reg_addr(7, 4'ha), rand64(), '0, cmd);
   repeat (20) begin
      check_flag("group_miss resp_valid", 1'b0, resp_valid);
      @(negedge clk);
   end
   read_reg("group_miss", 7); // still the value from reset_rw
endtask

task automatic test_back_pressure();
   umi_cmd_t  cmd_a;
   umi_cmd_t  cmd_b;
   umi_cmd_t  want_a;
   umi_addr_t src_a;
   umi_addr_t src_b;
   src_a = rand64();
   src_b = rand64();
   send_req(REQ_READ, 3'd3, reg_addr(9, '0), src_a, '0, cmd_a);
   resp_ready    = 1'b0; // before the first response edge
   want_a        = cmd_a;
   want_a.opcode = RESP_READ;
   drive_req(REQ_READ, 3'd3, reg_addr(10, '0), src_b, '0, cmd_b);
   repeat (10) begin
      @(negedge clk);
      check_flag("back_pressure resp_valid", 1'b1, resp_valid);
      check_flag("back_pressure req_ready", 1'b0, req_ready);
      check_cmd("back_pressure held cmd", want_a, umi_cmd_t'(resp_cmd));
      check_addr("back_pressure held dst", src_a, resp_dstaddr);
      check_data("back_pressure held data", model[9], resp_data[63:0]);
   end
   resp_ready = 1'b1;
   check_resp("back_pressure first", cmd_a, src_a, model[9]);
   wait_accept(); // second read goes in once the first is out
   check_resp("back_pressure second", cmd_b, src_b, model[10]);
endtask

`endif

/* tb_umi_dev.sv */
/* umi device testbench
   directed tests of reads, masked writes, atomic add, group decode and back-pressure */

`default_nettype none

`include "umi_defines.svh"

module tb_umi_dev
   import umi_pkg::*;
   ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int n_requests = 48;                  // requests over all tests
   localparam int wd_cycles  = 5 + n_requests * 200; // reset plus 200 per request

   logic          clk;
   logic          nreset;
   logic          req_valid;
   umi_cmd_word_t req_cmd;
   umi_addr_t     req_dstaddr;
   umi_addr_t     req_srcaddr;
   umi_data_t     req_data;
   logic          req_ready;
   logic          resp_valid;
   umi_cmd_word_t resp_cmd;
   umi_addr_t     resp_dstaddr;
   umi_addr_t     resp_srcaddr;
   umi_data_t     resp_data;
   logic          resp_ready;

   integer    seed;               // $random state
   int        n_checks;           // compares run
   int        n_errors;           // compares failed
   reg_data_t model [`UMI_NREGS]; // expected register contents

   umi_dev_top u_umi_dev_top (.*); // names match one to one

   `include "tb_umi_tasks.svh"

   //####################
   // clock and watchdog
   //####################
   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk; // 10 ns period
   end

   initial begin
      repeat (wd_cycles) @(posedge clk);
      $display("watchdog expired after %0d cycles, a handshake never completed", wd_cycles);
      $display("TEST FAILED");
      $finish;
   end

   //####################
   // test sequence
   //####################
   initial begin
      seed        = 32'h434b6c10;
      n_checks    = 0;
      n_errors    = 0;
      nreset      = 1'b0;
      req_valid   = 1'b0;
      req_cmd     = '0;
      req_dstaddr = '0;
      req_srcaddr = '0;
      req_data    = '0;
      resp_ready  = 1'b1; // sink always ready unless a test stalls it
      for (int i = 0; i < `UMI_NREGS; i++) begin
         model[i] = '0; // bank clears on reset
      end
      repeat (5) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;
      test_reset_rw();
      test_masked_write();
      test_atomic_add();
      test_group_miss();
      test_back_pressure();
      $display("checks run %0d, errors %0d", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
umi_pkg.sv
reg_if.sv
umi_regif.sv
umi_reg_file.sv
umi_dev_top.sv
tb_umi_dev.sv

/* run.sh */
#!/bin/sh
# build and run the umi device testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f filelist.f \
   --top-module tb_umi_dev -o sim_umi_dev

out=$(./obj_dir/sim_umi_dev)
echo "$out"
if echo "$out" | grep -q "^TEST PASSED$"; then
   exit 0
fi
exit 1
